// File: common/rv_check_pkg.sv
package rv_check_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    localparam word_t pc_step = 32'd4;    // every instruction is 4 bytes

    // RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_r      = 7'b0110011,
        opc_imm    = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_jalr   = 7'b1100111,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_fence  = 7'b0001111,
        opc_system = 7'b1110011     // ECALL, EBREAK
    } opcode_t;

    // operations that get a real result, everything else retires as cls_other
    typedef enum logic [2:0] {
        cls_other = 3'd0,
        cls_xori  = 3'd1,
        cls_lb    = 3'd2,
        cls_blt   = 3'd3,
        cls_jal   = 3'd4,
        cls_auipc = 3'd5
    } inst_class_t;

    // loads
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    // stores
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    // branches, 010 and 011 are reserved
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // immediate ALU
    localparam logic [2:0] f3_addi  = 3'b000;
    localparam logic [2:0] f3_slli  = 3'b001;
    localparam logic [2:0] f3_slti  = 3'b010;
    localparam logic [2:0] f3_sltiu = 3'b011;
    localparam logic [2:0] f3_xori  = 3'b100;
    localparam logic [2:0] f3_srli  = 3'b101;  // SRAI shares it, funct7 tells them apart
    localparam logic [2:0] f3_ori   = 3'b110;
    localparam logic [2:0] f3_andi  = 3'b111;

    // register ALU
    localparam logic [2:0] f3_add  = 3'b000;   // also SUB
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;   // also SRA
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] f3_fence   = 3'b000;
    localparam logic [2:0] f3_fence_i = 3'b001;
    localparam logic [2:0] f3_jalr    = 3'b000;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;  // SUB, SRA, SRAI

endpackage

// File: rtl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid_i,
    input  rv_check_pkg::word_t       inst_i,
    input  rv_check_pkg::word_t       pc_i,
    input  rv_check_pkg::word_t       rs1_val_i,
    input  rv_check_pkg::word_t       rs2_val_i,
    output logic                      dec_valid_o,
    output logic                      dec_legal_o,
    output rv_check_pkg::inst_class_t dec_class_o,
    output rv_check_pkg::reg_addr_t   dec_rd_o,
    output rv_check_pkg::word_t       dec_imm_o,
    output rv_check_pkg::word_t       dec_pc_o,
    output rv_check_pkg::word_t       dec_rs1_val_o,
    output rv_check_pkg::word_t       dec_rs2_val_o
);

    rv_check_pkg::opcode_t     opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    rv_check_pkg::word_t       imm_i;
    rv_check_pkg::word_t       imm_b;
    rv_check_pkg::word_t       imm_j;
    rv_check_pkg::word_t       imm_u;
    rv_check_pkg::word_t       imm;
    logic                      legal;
    rv_check_pkg::inst_class_t cls;

    assign opcode = rv_check_pkg::opcode_t'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    always_comb begin
        case (opcode)
            rv_check_pkg::opc_branch: imm = imm_b;
            rv_check_pkg::opc_jal:    imm = imm_j;
            rv_check_pkg::opc_lui,
            rv_check_pkg::opc_auipc:  imm = imm_u;
            default:                  imm = imm_i;   // I format, also loads and JALR
        endcase
    end

    always_comb begin
        legal = 1'b0;
        case (opcode)
            rv_check_pkg::opc_lui,
            rv_check_pkg::opc_auipc: legal = 1'b1;
            rv_check_pkg::opc_jal:   legal = ~imm_j[1];  // target must stay word aligned
            rv_check_pkg::opc_jalr:  legal = (funct3 == rv_check_pkg::f3_jalr) &&
                                             (imm_i[1:0] == 2'b00);
            rv_check_pkg::opc_branch: begin
                case (funct3)
                    rv_check_pkg::f3_beq, rv_check_pkg::f3_bne,
                    rv_check_pkg::f3_blt, rv_check_pkg::f3_bge,
                    rv_check_pkg::f3_bltu, rv_check_pkg::f3_bgeu: legal = ~imm_b[1];
                    default: legal = 1'b0;
                endcase
            end
            rv_check_pkg::opc_load: begin
                case (funct3)
                    rv_check_pkg::f3_lb, rv_check_pkg::f3_lh, rv_check_pkg::f3_lw,
                    rv_check_pkg::f3_lbu, rv_check_pkg::f3_lhu: legal = 1'b1;
                    default: legal = 1'b0;
                endcase
            end
            rv_check_pkg::opc_store: begin
                case (funct3)
                    rv_check_pkg::f3_sb, rv_check_pkg::f3_sh,
                    rv_check_pkg::f3_sw: legal = 1'b1;
                    default: legal = 1'b0;
                endcase
            end
            rv_check_pkg::opc_imm: begin
                case (funct3)
                    rv_check_pkg::f3_slli: legal = (funct7 == rv_check_pkg::funct7_base);
                    rv_check_pkg::f3_srli: legal = (funct7 == rv_check_pkg::funct7_base) ||
                                                   (funct7 == rv_check_pkg::funct7_alt);
                    rv_check_pkg::f3_addi, rv_check_pkg::f3_slti, rv_check_pkg::f3_sltiu,
                    rv_check_pkg::f3_xori, rv_check_pkg::f3_ori,
                    rv_check_pkg::f3_andi: legal = 1'b1;     // funct7 bits are immediate
                    default: legal = 1'b0;
                endcase
            end
            rv_check_pkg::opc_r: begin
                case (funct3)
                    rv_check_pkg::f3_add,
                    rv_check_pkg::f3_srl: legal = (funct7 == rv_check_pkg::funct7_base) ||
                                                  (funct7 == rv_check_pkg::funct7_alt);
                    rv_check_pkg::f3_sll, rv_check_pkg::f3_slt, rv_check_pkg::f3_sltu,
                    rv_check_pkg::f3_xor, rv_check_pkg::f3_or,
                    rv_check_pkg::f3_and: legal = (funct7 == rv_check_pkg::funct7_base);
                    default: legal = 1'b0;
                endcase
            end
            rv_check_pkg::opc_fence: begin
                // rd and rs1 are zero for both forms
                if (funct3 == rv_check_pkg::f3_fence) begin
                    legal = (inst_i[31:28] == 4'b0) && (inst_i[19:15] == 5'b0) &&
                            (inst_i[11:7] == 5'b0);
                end else if (funct3 == rv_check_pkg::f3_fence_i) begin
                    legal = (inst_i[31:15] == 17'b0) && (inst_i[11:7] == 5'b0);
                end
            end
            // inst[20] picks ECALL or EBREAK
            rv_check_pkg::opc_system: legal = (inst_i[31:21] == 11'b0) &&
                                              (inst_i[19:7] == 13'b0);
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        cls = rv_check_pkg::cls_other;
        if (legal) begin
            case (opcode)
                rv_check_pkg::opc_imm: begin
                    if (funct3 == rv_check_pkg::f3_xori) cls = rv_check_pkg::cls_xori;
                end
                rv_check_pkg::opc_load: begin
                    if (funct3 == rv_check_pkg::f3_lb) cls = rv_check_pkg::cls_lb;
                end
                rv_check_pkg::opc_branch: begin
                    if (funct3 == rv_check_pkg::f3_blt) cls = rv_check_pkg::cls_blt;
                end
                rv_check_pkg::opc_jal:   cls = rv_check_pkg::cls_jal;
                rv_check_pkg::opc_auipc: cls = rv_check_pkg::cls_auipc;
                default:                 cls = rv_check_pkg::cls_other;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            dec_legal_o   <= legal;
            dec_class_o   <= cls;
            dec_rd_o      <= inst_i[11:7];
            dec_imm_o     <= imm;
            dec_pc_o      <= pc_i;
            dec_rs1_val_o <= rs1_val_i;
            dec_rs2_val_o <= rs2_val_i;
        end
    end

endmodule

// File: rtl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dec_valid_i,
    input  logic                      dec_legal_i,
    input  rv_check_pkg::inst_class_t dec_class_i,
    input  rv_check_pkg::reg_addr_t   dec_rd_i,
    input  rv_check_pkg::word_t       dec_imm_i,
    input  rv_check_pkg::word_t       dec_pc_i,
    input  rv_check_pkg::word_t       dec_rs1_val_i,
    input  rv_check_pkg::word_t       dec_rs2_val_i,
    output logic                      ex_valid_o,
    output logic                      ex_legal_o,
    output rv_check_pkg::inst_class_t ex_class_o,
    output rv_check_pkg::reg_addr_t   ex_rd_o,
    output rv_check_pkg::word_t       ex_data_o,
    output rv_check_pkg::word_t       ex_next_pc_o,
    output logic [1:0]                ex_byte_sel_o,
    output logic                      mem_req_o,
    output rv_check_pkg::word_t       mem_addr_o
);

    rv_check_pkg::word_t pc_plus_step;
    rv_check_pkg::word_t pc_plus_imm;
    rv_check_pkg::word_t lb_addr;
    rv_check_pkg::word_t data;
    rv_check_pkg::word_t next_pc;
    logic                blt_taken;

    assign pc_plus_step = dec_pc_i + rv_check_pkg::pc_step;
    assign pc_plus_imm  = dec_pc_i + dec_imm_i;    // branch, jump and AUIPC share it
    assign lb_addr      = dec_rs1_val_i + dec_imm_i;
    assign blt_taken    = $signed(dec_rs1_val_i) < $signed(dec_rs2_val_i);

    always_comb begin
        data    = '0;
        next_pc = pc_plus_step;
        case (dec_class_i)
            rv_check_pkg::cls_xori:  data = dec_rs1_val_i ^ dec_imm_i;
            rv_check_pkg::cls_auipc: data = pc_plus_imm;
            rv_check_pkg::cls_jal: begin
                data    = pc_plus_step;            // link address
                next_pc = pc_plus_imm;
            end
            rv_check_pkg::cls_blt: begin
                if (blt_taken) next_pc = pc_plus_imm;
            end
            default: data = '0;   // LB data comes from memory in the next stage
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_o <= 1'b0;
            mem_req_o  <= 1'b0;
        end else begin
            ex_valid_o <= dec_valid_i;
            mem_req_o  <= dec_valid_i && (dec_class_i == rv_check_pkg::cls_lb);
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            ex_legal_o    <= dec_legal_i;
            ex_class_o    <= dec_class_i;
            ex_rd_o       <= dec_rd_i;
            ex_data_o     <= data;
            ex_next_pc_o  <= next_pc;
            ex_byte_sel_o <= lb_addr[1:0];
            mem_addr_o    <= lb_addr;
        end
    end

endmodule

// File: rtl/rv_result.sv
`timescale 1ns/1ps

module rv_result (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ex_valid_i,
    input  logic                      ex_legal_i,
    input  rv_check_pkg::inst_class_t ex_class_i,
    input  rv_check_pkg::reg_addr_t   ex_rd_i,
    input  rv_check_pkg::word_t       ex_data_i,
    input  rv_check_pkg::word_t       ex_next_pc_i,
    input  logic [1:0]                ex_byte_sel_i,
    input  rv_check_pkg::word_t       mem_rdata_i,
    output logic                      res_valid_o,
    output logic                      res_legal_o,
    output logic                      res_we_o,
    output rv_check_pkg::reg_addr_t   res_rd_o,
    output rv_check_pkg::word_t       res_data_o,
    output rv_check_pkg::word_t       res_next_pc_o
);

    logic [7:0]          load_byte;
    rv_check_pkg::word_t wr_data;
    logic                writes_rd;
    logic                we;

    always_comb begin
        case (ex_byte_sel_i)
            2'd0:    load_byte = mem_rdata_i[7:0];
            2'd1:    load_byte = mem_rdata_i[15:8];
            2'd2:    load_byte = mem_rdata_i[23:16];
            default: load_byte = mem_rdata_i[31:24];
        endcase
    end

    always_comb begin
        case (ex_class_i)
            rv_check_pkg::cls_xori, rv_check_pkg::cls_lb,
            rv_check_pkg::cls_jal, rv_check_pkg::cls_auipc: writes_rd = 1'b1;
            default: writes_rd = 1'b0;    // BLT and the rest
        endcase
    end

    assign wr_data = (ex_class_i == rv_check_pkg::cls_lb) ? {{24{load_byte[7]}}, load_byte}
                                                          : ex_data_i;
    assign we = ex_valid_i && ex_legal_i && writes_rd && (ex_rd_i != '0);  // x0 never written

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_o <= 1'b0;
            res_we_o    <= 1'b0;
        end else begin
            res_valid_o <= ex_valid_i;
            res_we_o    <= we;
        end
    end

    always_ff @(posedge clk) begin
        res_data_o <= we ? wr_data : '0;
        if (ex_valid_i) begin
            res_legal_o   <= ex_legal_i;
            res_rd_o      <= ex_rd_i;
            res_next_pc_o <= ex_next_pc_i;
        end
    end

endmodule

// File: rtl/rv_check_top.sv
`timescale 1ns/1ps

module rv_check_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst_valid_i,
    input  rv_check_pkg::word_t     inst_i,
    input  rv_check_pkg::word_t     pc_i,
    input  rv_check_pkg::word_t     rs1_val_i,
    input  rv_check_pkg::word_t     rs2_val_i,
    input  rv_check_pkg::word_t     mem_rdata_i,
    output logic                    mem_req_o,
    output rv_check_pkg::word_t     mem_addr_o,
    output logic                    res_valid_o,
    output logic                    res_legal_o,
    output logic                    res_we_o,
    output rv_check_pkg::reg_addr_t res_rd_o,
    output rv_check_pkg::word_t     res_data_o,
    output rv_check_pkg::word_t     res_next_pc_o
);

    // decode to execute
    logic                      dec_valid;
    logic                      dec_legal;
    rv_check_pkg::inst_class_t dec_class;
    rv_check_pkg::reg_addr_t   dec_rd;
    rv_check_pkg::word_t       dec_imm;
    rv_check_pkg::word_t       dec_pc;
    rv_check_pkg::word_t       dec_rs1_val;
    rv_check_pkg::word_t       dec_rs2_val;

    // execute to result
    logic                      ex_valid;
    logic                      ex_legal;
    rv_check_pkg::inst_class_t ex_class;
    rv_check_pkg::reg_addr_t   ex_rd;
    rv_check_pkg::word_t       ex_data;
    rv_check_pkg::word_t       ex_next_pc;
    logic [1:0]                ex_byte_sel;

    rv_decode u_decode (
        .clk           (clk),
        .rst           (rst),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .rs1_val_i     (rs1_val_i),
        .rs2_val_i     (rs2_val_i),
        .dec_valid_o   (dec_valid),
        .dec_legal_o   (dec_legal),
        .dec_class_o   (dec_class),
        .dec_rd_o      (dec_rd),
        .dec_imm_o     (dec_imm),
        .dec_pc_o      (dec_pc),
        .dec_rs1_val_o (dec_rs1_val),
        .dec_rs2_val_o (dec_rs2_val)
    );

    rv_execute u_execute (
        .clk           (clk),
        .rst           (rst),
        .dec_valid_i   (dec_valid),
        .dec_legal_i   (dec_legal),
        .dec_class_i   (dec_class),
        .dec_rd_i      (dec_rd),
        .dec_imm_i     (dec_imm),
        .dec_pc_i      (dec_pc),
        .dec_rs1_val_i (dec_rs1_val),
        .dec_rs2_val_i (dec_rs2_val),
        .ex_valid_o    (ex_valid),
        .ex_legal_o    (ex_legal),
        .ex_class_o    (ex_class),
        .ex_rd_o       (ex_rd),
        .ex_data_o     (ex_data),
        .ex_next_pc_o  (ex_next_pc),
        .ex_byte_sel_o (ex_byte_sel),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o)
    );

    // read word arrives while mem_req_o is high, result stage samples it
    rv_result u_result (
        .clk           (clk),
        .rst           (rst),
        .ex_valid_i    (ex_valid),
        .ex_legal_i    (ex_legal),
        .ex_class_i    (ex_class),
        .ex_rd_i       (ex_rd),
        .ex_data_i     (ex_data),
        .ex_next_pc_i  (ex_next_pc),
        .ex_byte_sel_i (ex_byte_sel),
        .mem_rdata_i   (mem_rdata_i),
        .res_valid_o   (res_valid_o),
        .res_legal_o   (res_legal_o),
        .res_we_o      (res_we_o),
        .res_rd_o      (res_rd_o),
        .res_data_o    (res_data_o),
        .res_next_pc_o (res_next_pc_o)
    );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    localparam time half_period = 20ns;   // 40 ns clock

    initial clk_o = 1'b0;

    always #(half_period) clk_o = ~clk_o;

endmodule

// File: verif/tb_rv_check.sv
`timescale 1ns/1ps

module tb_rv_check;

    localparam int timeout_cycles = 20;
    localparam int latency        = 3;
    localparam int req_latency    = 2;

    logic                    clk;
    logic                    rst;
    logic                    inst_valid_i;
    rv_check_pkg::word_t     inst_i;
    rv_check_pkg::word_t     pc_i;
    rv_check_pkg::word_t     rs1_val_i;
    rv_check_pkg::word_t     rs2_val_i;
    rv_check_pkg::word_t     mem_rdata_i;
    logic                    mem_req_o;
    rv_check_pkg::word_t     mem_addr_o;
    logic                    res_valid_o;
    logic                    res_legal_o;
    logic                    res_we_o;
    rv_check_pkg::reg_addr_t res_rd_o;
    rv_check_pkg::word_t     res_data_o;
    rv_check_pkg::word_t     res_next_pc_o;

    rv_check_pkg::word_t     mem_word = '0;   // the one stored word of the ideal memory
    int                      cycle_cnt = 0;
    int                      strobe_q[$];     // cycle of each strobe, oldest first

    tb_clock u_clock (.clk_o(clk));

    rv_check_top uut (
        .clk           (clk),
        .rst           (rst),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .rs1_val_i     (rs1_val_i),
        .rs2_val_i     (rs2_val_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .res_valid_o   (res_valid_o),
        .res_legal_o   (res_legal_o),
        .res_we_o      (res_we_o),
        .res_rd_o      (res_rd_o),
        .res_data_o    (res_data_o),
        .res_next_pc_o (res_next_pc_o)
    );

    // answers in the same cycle as the request
    always_comb mem_rdata_i = (mem_req_o === 1'b1) ? mem_word : '0;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles while waiting for %s", timeout_cycles, what);
        stop_run();
    endtask

    task automatic check_word(input string name, input rv_check_pkg::word_t exp,
                              input rv_check_pkg::word_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_reg(input string name, input rv_check_pkg::reg_addr_t exp,
                             input rv_check_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    function automatic rv_check_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic rv_check_pkg::word_t rand_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    function automatic rv_check_pkg::reg_addr_t rand_rd();
        return rv_check_pkg::reg_addr_t'($urandom_range(31, 1));   // never x0
    endfunction

    function automatic rv_check_pkg::word_t enc_i(input logic [11:0] imm,
                                                  input logic [2:0] f3,
                                                  input rv_check_pkg::reg_addr_t rd,
                                                  input logic [6:0] opc);
        return {imm, rv_check_pkg::reg_addr_t'($urandom), f3, rd, opc};
    endfunction

    function automatic rv_check_pkg::word_t enc_b(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], rv_check_pkg::reg_addr_t'($urandom),
                rv_check_pkg::reg_addr_t'($urandom), f3, off[4:1], off[11],
                rv_check_pkg::opc_branch};
    endfunction

    function automatic rv_check_pkg::word_t enc_j(input logic [20:0] off,
                                                  input rv_check_pkg::reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_check_pkg::opc_jal};
    endfunction

    task automatic drive_inst(input rv_check_pkg::word_t inst, input rv_check_pkg::word_t pc,
                              input rv_check_pkg::word_t rs1, input rv_check_pkg::word_t rs2);
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        pc_i         <= pc;
        rs1_val_i    <= rs1;
        rs2_val_i    <= rs2;
        @(negedge clk);
        strobe_q.push_back(cycle_cnt);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        inst_valid_i <= 1'b0;
    endtask

    task automatic wait_mem_req();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > timeout_cycles) report_timeout("mem_req_o");
        end while (mem_req_o !== 1'b1);
        if (cycle_cnt - strobe_q[$] != req_latency) begin
            $display("mem_req_o came %0d cycles after its strobe, %0d expected",
                     cycle_cnt - strobe_q[$], req_latency);
            stop_run();
        end
    endtask

    // waits for the next result and compares every field
    task automatic expect_result(input rv_check_pkg::word_t inst, input logic legal,
                                 input logic we, input rv_check_pkg::word_t data,
                                 input rv_check_pkg::word_t next_pc);
        int waited;
        int strobe;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > timeout_cycles) report_timeout("res_valid_o");
        end while (res_valid_o !== 1'b1);
        strobe = strobe_q.pop_front();
        if (cycle_cnt - strobe != latency) begin
            $display("result came %0d cycles after its strobe, %0d expected",
                     cycle_cnt - strobe, latency);
            stop_run();
        end
        check_bit("res_legal_o", legal, res_legal_o);
        check_bit("res_we_o", we, res_we_o);
        check_reg("res_rd_o", inst[11:7], res_rd_o);   // rd is the field of the word
        check_word("res_data_o", data, res_data_o);
        check_word("res_next_pc_o", next_pc, res_next_pc_o);
    endtask

    task automatic run_one(input rv_check_pkg::word_t inst, input rv_check_pkg::word_t pc,
                           input logic legal, input logic we,
                           input rv_check_pkg::word_t data, input rv_check_pkg::word_t next_pc,
                           input rv_check_pkg::word_t rs1, input rv_check_pkg::word_t rs2);
        drive_inst(inst, pc, rs1, rs2);
        drive_idle();
        repeat (req_latency) @(negedge clk);
        check_bit("mem_req_o", 1'b0, mem_req_o);   // only LB reads memory
        expect_result(inst, legal, we, data, next_pc);
        @(negedge clk);
        check_bit("res_valid_o", 1'b0, res_valid_o);   // one-cycle pulse
    endtask

    task automatic xori_results();
        rv_check_pkg::word_t rs1;
        rv_check_pkg::word_t pc;
        rv_check_pkg::word_t inst;
        logic [11:0]         imm;
        for (int i = 0; i < 4; i++) begin
            rs1     = $urandom;
            pc      = rand_pc();
            imm     = 12'($urandom);
            imm[11] = i[0];   // both immediate signs
            inst    = enc_i(imm, rv_check_pkg::f3_xori, rand_rd(), rv_check_pkg::opc_imm);
            run_one(inst, pc, 1'b1, 1'b1, rs1 ^ sext12(imm), pc + 32'd4, rs1, $urandom);
        end
        inst[11:7] = 5'd0;
        run_one(inst, pc, 1'b1, 1'b0, '0, pc + 32'd4, rs1, $urandom);
    endtask

    task automatic lb_offsets();
        rv_check_pkg::word_t addr;
        rv_check_pkg::word_t pc;
        rv_check_pkg::word_t inst;
        logic [11:0]         imm;
        logic [7:0]          b;
        for (int off = 0; off < 4; off++) begin
            for (int neg = 0; neg < 2; neg++) begin
                imm  = 12'($urandom);
                addr = ($urandom & 32'hffff_fffc) | rv_check_pkg::word_t'(off);
                b    = 8'($urandom);
                b[7] = neg[0];
                mem_word = $urandom;
                mem_word[off*8 +: 8] = b;
                pc   = rand_pc();
                inst = enc_i(imm, rv_check_pkg::f3_lb, rand_rd(), rv_check_pkg::opc_load);
                drive_inst(inst, pc, addr - sext12(imm), $urandom);
                drive_idle();
                wait_mem_req();
                check_word("mem_addr_o", addr, mem_addr_o);
                expect_result(inst, 1'b1, 1'b1, {{24{b[7]}}, b}, pc + 32'd4);
            end
        end
    endtask

    task automatic blt_outcomes();
        rv_check_pkg::word_t a;
        rv_check_pkg::word_t b;
        rv_check_pkg::word_t pc;
        logic [12:0]         off;
        for (int k = 0; k < 3; k++) begin
            off      = 13'($urandom);
            off[1:0] = 2'b00;
            pc       = rand_pc();
            a        = $urandom;
            b        = $urandom;
            case (k)
                0: begin    // signed less but unsigned greater
                    a[31] = 1'b1;
                    b[31] = 1'b0;
                end
                1: b = a;
                default: begin
                    a[31] = 1'b0;
                    b[31] = 1'b1;
                end
            endcase
            run_one(enc_b(off, rv_check_pkg::f3_blt), pc, 1'b1, 1'b0, '0,
                    (k == 0) ? pc + {{19{off[12]}}, off} : pc + 32'd4, a, b);
        end
    endtask

    task automatic jal_auipc();
        rv_check_pkg::word_t pc;
        logic [20:0]         off;
        logic [19:0]         upper;
        pc       = rand_pc();
        off      = 21'($urandom);
        off[1:0] = 2'b00;
        run_one(enc_j(off, rand_rd()), pc, 1'b1, 1'b1, pc + 32'd4,
                pc + {{11{off[20]}}, off}, $urandom, $urandom);
        pc    = rand_pc();
        upper = 20'($urandom);
        run_one({upper, rand_rd(), rv_check_pkg::opc_auipc}, pc, 1'b1, 1'b1,
                pc + {upper, 12'b0}, pc + 32'd4, $urandom, $urandom);
    endtask

    task automatic illegal_encodings();
        rv_check_pkg::word_t pc;
        logic [12:0]         boff;
        logic [20:0]         joff;
        pc       = rand_pc();
        boff     = 13'($urandom);
        boff[1:0] = 2'b00;
        run_one(enc_b(boff, 3'b010), pc, 1'b0, 1'b0, '0, pc + 32'd4, $urandom, $urandom);
        joff      = 21'($urandom);
        joff[1:0] = 2'b10;    // half-word target
        run_one(enc_j(joff, rand_rd()), pc, 1'b0, 1'b0, '0, pc + 32'd4, $urandom, $urandom);
        run_one({25'($urandom), 7'b1111111}, pc, 1'b0, 1'b0, '0, pc + 32'd4,
                $urandom, $urandom);
        // plain ADD is legal but has no modeled result
        run_one({rv_check_pkg::funct7_base, rv_check_pkg::reg_addr_t'($urandom),
                 rv_check_pkg::reg_addr_t'($urandom), rv_check_pkg::f3_add, rand_rd(),
                 rv_check_pkg::opc_r}, pc, 1'b1, 1'b0, '0, pc + 32'd4, $urandom, $urandom);
    endtask

    task automatic back_to_back();
        rv_check_pkg::word_t inst[3];
        rv_check_pkg::word_t pc[3];
        rv_check_pkg::word_t data[3];
        rv_check_pkg::word_t next_pc[3];
        rv_check_pkg::word_t rs1;
        logic [11:0]         imm;
        logic [20:0]         off;
        for (int i = 0; i < 3; i++) pc[i] = rand_pc();
        rs1        = $urandom;
        imm        = 12'($urandom);
        inst[0]    = enc_i(imm, rv_check_pkg::f3_xori, rand_rd(), rv_check_pkg::opc_imm);
        data[0]    = rs1 ^ sext12(imm);
        next_pc[0] = pc[0] + 32'd4;
        off        = {19'($urandom), 2'b00};
        inst[1]    = enc_j(off, rand_rd());
        data[1]    = pc[1] + 32'd4;
        next_pc[1] = pc[1] + {{11{off[20]}}, off};
        inst[2]    = {inst[0][31:12], rand_rd(), rv_check_pkg::opc_auipc};
        data[2]    = pc[2] + {inst[0][31:12], 12'b0};
        next_pc[2] = pc[2] + 32'd4;
        // three in flight fills the pipe
        for (int i = 0; i < 3; i++) drive_inst(inst[i], pc[i], rs1, $urandom);
        drive_idle();
        for (int i = 0; i < 3; i++) expect_result(inst[i], 1'b1, 1'b1, data[i], next_pc[i]);
    endtask

    initial begin
        void'($urandom(32'h46421a7d));
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        rs1_val_i    = '0;
        rs2_val_i    = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        xori_results();
        lb_offsets();
        blt_outcomes();
        jal_auipc();
        illegal_encodings();
        back_to_back();

        $display("test passed");
        $finish;
    end

endmodule

// File: rv_check.f
common/rv_check_pkg.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_check_top.sv
verif/tb_clock.sv
verif/tb_rv_check.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_rv_check
FILELIST = rv_check.f

SRCS     := $(filter %.sv %.v,$(shell cat $(FILELIST)))
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "test passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
